/* design/regfile_pkg.sv */
package regfile_pkg;

    // word and address widths
    localparam int data_w = 32;
    localparam int addr_w = 7;

    // hi/lo live in the bit-6 space
    localparam logic [addr_w-1:0] hi_addr = 7'h7F;
    localparam logic [addr_w-1:0] lo_addr = 7'h40;

    // coprocessor 0 register indices
    localparam logic [4:0] cp0_badvaddr = 5'd8;
    localparam logic [4:0] cp0_status   = 5'd12;
    localparam logic [4:0] cp0_cause    = 5'd13;
    localparam logic [4:0] cp0_epc      = 5'd14;

    // status fields
    localparam int st_ie    = 0;
    localparam int st_exl   = 1;
    localparam int st_im_lo = 8;
    localparam int st_im_hi = 15;

    // cause fields
    localparam int ca_exc_lo = 2;
    localparam int ca_exc_hi = 6;
    localparam int ca_ip_lo  = 8;
    localparam int ca_ip_hi  = 15;
    localparam int ca_bd     = 31;

    // one address word seen whole or as bank select plus index
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic       hilo_sel;  // bit 6
            logic       cp0_sel;   // bit 5
            logic [4:0] index;
        } f;
    } reg_addr_u;

endpackage

/* design/gpr_bank.sv */
`timescale 1ns/1ps

module gpr_bank (
    input  logic                          clk,
    input  logic                          we,
    input  logic [4:0]                    waddr,
    input  logic [regfile_pkg::data_w-1:0] wdata,
    input  logic [3:0]                    byte_we,
    input  logic [4:0]                    raddr1,
    input  logic [4:0]                    raddr2,
    output logic [regfile_pkg::data_w-1:0] rdata1,
    output logic [regfile_pkg::data_w-1:0] rdata2
);

    logic [regfile_pkg::data_w-1:0] mem [0:31];

    // r0 is never written, the top forces it to zero on read
    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_we[i]) begin
                    mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // raw storage, bypass is done above this bank
    assign rdata1 = mem[raddr1];
    assign rdata2 = mem[raddr2];

endmodule

/* design/hilo_regs.sv */
`timescale 1ns/1ps

module hilo_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hl_we,
    input  logic [2*regfile_pkg::data_w-1:0] hl_data,
    input  logic                          hi_we,
    input  logic                          lo_we,
    input  logic [regfile_pkg::data_w-1:0] wdata,
    output logic [regfile_pkg::data_w-1:0] hi,
    output logic [regfile_pkg::data_w-1:0] lo
);

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (hl_we) begin
            // mult/div result beats mthi/mtlo
            hi <= hl_data[2*regfile_pkg::data_w-1:regfile_pkg::data_w];
            lo <= hl_data[regfile_pkg::data_w-1:0];
        end else begin
            if (hi_we) begin
                hi <= wdata;
            end
            if (lo_we) begin
                lo <= wdata;
            end
        end
    end

endmodule

/* design/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          we,
    input  logic [4:0]                    waddr,
    input  logic [regfile_pkg::data_w-1:0] wdata,
    input  logic [4:0]                    raddr,
    input  logic                          exc_we,
    input  logic                          eret,
    input  logic [4:0]                    exc_code,
    input  logic                          branch_delay,
    input  logic [regfile_pkg::data_w-1:0] epc,
    input  logic [regfile_pkg::data_w-1:0] badaddr,
    input  logic [5:0]                    hw_int,
    output logic [regfile_pkg::data_w-1:0] rdata,
    output logic [regfile_pkg::data_w-1:0] status_data,
    output logic [regfile_pkg::data_w-1:0] cause_data,
    output logic [regfile_pkg::data_w-1:0] epc_data,
    output logic                          int_request
);

    logic [regfile_pkg::data_w-1:0] status_q;
    logic [regfile_pkg::data_w-1:0] cause_q;
    logic [regfile_pkg::data_w-1:0] epc_q;
    logic [regfile_pkg::data_w-1:0] badvaddr_q;
    logic                           status_wr;
    logic                           cause_wr;
    logic                           epc_wr;

    assign status_wr = we && waddr == regfile_pkg::cp0_status;
    assign cause_wr  = we && waddr == regfile_pkg::cp0_cause;
    assign epc_wr    = we && waddr == regfile_pkg::cp0_epc;

    // status: only IM, EXL and IE are writable
    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= '0;
        end else begin
            if (status_wr) begin
                status_q[regfile_pkg::st_im_hi:regfile_pkg::st_im_lo] <=
                    wdata[regfile_pkg::st_im_hi:regfile_pkg::st_im_lo];
                status_q[regfile_pkg::st_exl] <= wdata[regfile_pkg::st_exl];
                status_q[regfile_pkg::st_ie]  <= wdata[regfile_pkg::st_ie];
            end
            if (eret) status_q[regfile_pkg::st_exl] <= 1'b0;
            if (exc_we) status_q[regfile_pkg::st_exl] <= 1'b1;  // exception beats eret
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cause_q <= '0;
        end else begin
            if (cause_wr) begin
                cause_q[regfile_pkg::ca_ip_lo +: 2] <= wdata[regfile_pkg::ca_ip_lo +: 2];
            end
            cause_q[regfile_pkg::ca_ip_hi -: 6] <= hw_int;  // sampled every edge
            if (exc_we) begin
                cause_q[regfile_pkg::ca_exc_hi:regfile_pkg::ca_exc_lo] <= exc_code;
                cause_q[regfile_pkg::ca_bd] <= branch_delay;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            epc_q      <= '0;
            badvaddr_q <= '0;
        end else begin
            if (epc_wr) epc_q <= wdata;
            if (exc_we) begin
                epc_q      <= epc;
                badvaddr_q <= badaddr;
            end
        end
    end

    always_comb begin
        case (raddr)
            regfile_pkg::cp0_status:   rdata = status_q;
            regfile_pkg::cp0_cause:    rdata = cause_q;
            regfile_pkg::cp0_epc:      rdata = epc_q;
            regfile_pkg::cp0_badvaddr: rdata = badvaddr_q;
            default:                   rdata = '0;
        endcase
    end

    assign status_data = status_q;
    assign cause_data  = cause_q;
    assign epc_data    = epc_q;

    // pending and unmasked, interrupts enabled, not in exception level
    assign int_request = status_q[regfile_pkg::st_ie] & ~status_q[regfile_pkg::st_exl] &
        |(cause_q[regfile_pkg::ca_ip_hi:regfile_pkg::ca_ip_lo] &
          status_q[regfile_pkg::st_im_hi:regfile_pkg::st_im_lo]);

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             regwrite,
    input  logic [regfile_pkg::addr_w-1:0]   write_addr,
    input  logic [regfile_pkg::data_w-1:0]   write_data,
    input  logic [3:0]                       byte_we,
    input  logic [regfile_pkg::addr_w-1:0]   read_addr_1,
    input  logic [regfile_pkg::addr_w-1:0]   read_addr_2,
    input  logic                             hl_we,
    input  logic [2*regfile_pkg::data_w-1:0] hl_data,
    input  logic                             exc_we,
    input  logic                             eret,
    input  logic [4:0]                       exc_code,
    input  logic                             branch_delay,
    input  logic [regfile_pkg::data_w-1:0]   epc,
    input  logic [regfile_pkg::data_w-1:0]   badaddr,
    input  logic [5:0]                       hw_int,
    output logic [regfile_pkg::data_w-1:0]   read_data_1,
    output logic [regfile_pkg::data_w-1:0]   read_data_2,
    output logic [regfile_pkg::data_w-1:0]   status_data,
    output logic [regfile_pkg::data_w-1:0]   cause_data,
    output logic [regfile_pkg::data_w-1:0]   epc_data,
    output logic                             int_request
);

    regfile_pkg::reg_addr_u         waddr_u, raddr1_u, raddr2_u;
    logic                           gpr_we, cp0_we, hi_we, lo_we;
    logic [regfile_pkg::data_w-1:0] gpr_rdata1, gpr_rdata2;
    logic [regfile_pkg::data_w-1:0] hi_q, lo_q;
    logic [regfile_pkg::data_w-1:0] cp0_rdata;

    // zero, write-back bypass, mult/div bypass, then stored value
    function automatic logic [regfile_pkg::data_w-1:0] read_mux(
        input regfile_pkg::reg_addr_u         a,
        input logic [regfile_pkg::data_w-1:0] gpr_val,
        input logic [regfile_pkg::data_w-1:0] cp0_val
    );
        if (a.raw == '0) return '0;
        if (regwrite && a.raw == waddr_u.raw) return write_data;
        if (a.f.hilo_sel) begin
            if (hl_we) begin
                return (a.raw == regfile_pkg::hi_addr) ?
                    hl_data[2*regfile_pkg::data_w-1:regfile_pkg::data_w] :
                    hl_data[regfile_pkg::data_w-1:0];
            end
            return (a.raw == regfile_pkg::hi_addr) ? hi_q : lo_q;
        end
        if (a.f.cp0_sel) return cp0_val;
        return gpr_val;
    endfunction

    assign waddr_u.raw  = write_addr;
    assign raddr1_u.raw = read_addr_1;
    assign raddr2_u.raw = read_addr_2;

    // bit 6 outranks bit 5, unused bit-6 addresses drop the write
    assign gpr_we = regwrite & ~waddr_u.f.hilo_sel & ~waddr_u.f.cp0_sel;
    assign cp0_we = regwrite & ~waddr_u.f.hilo_sel & waddr_u.f.cp0_sel;
    assign hi_we  = regwrite && waddr_u.raw == regfile_pkg::hi_addr;
    assign lo_we  = regwrite && waddr_u.raw == regfile_pkg::lo_addr;

    always_comb begin
        read_data_1 = read_mux(raddr1_u, gpr_rdata1, '0);  // no cp0 on port 1
        read_data_2 = read_mux(raddr2_u, gpr_rdata2, cp0_rdata);
    end

    gpr_bank u_gpr (
        .clk     (clk),
        .we      (gpr_we),
        .waddr   (waddr_u.f.index),
        .wdata   (write_data),
        .byte_we (byte_we),
        .raddr1  (raddr1_u.f.index),
        .raddr2  (raddr2_u.f.index),
        .rdata1  (gpr_rdata1),
        .rdata2  (gpr_rdata2)
    );

    hilo_regs u_hilo (
        .clk     (clk),
        .rst     (rst),
        .hl_we   (hl_we),
        .hl_data (hl_data),
        .hi_we   (hi_we),
        .lo_we   (lo_we),
        .wdata   (write_data),
        .hi      (hi_q),
        .lo      (lo_q)
    );

    cp0_regs u_cp0 (
        .clk          (clk),
        .rst          (rst),
        .we           (cp0_we),
        .waddr        (waddr_u.f.index),
        .wdata        (write_data),
        .raddr        (raddr2_u.f.index),
        .exc_we       (exc_we),
        .eret         (eret),
        .exc_code     (exc_code),
        .branch_delay (branch_delay),
        .epc          (epc),
        .badaddr      (badaddr),
        .hw_int       (hw_int),
        .rdata        (cp0_rdata),
        .status_data  (status_data),
        .cause_data   (cause_data),
        .epc_data     (epc_data),
        .int_request  (int_request)
    );

endmodule

/* bench/regfile_model.svh */
`ifndef REGFILE_MODEL_SVH
`define REGFILE_MODEL_SVH

// shadow state, stepped once per clock edge
logic [31:0] gpr_sh [0:31];
logic [31:0] hi_sh;
logic [31:0] lo_sh;
logic [31:0] status_sh;
logic [31:0] cause_sh;
logic [31:0] epc_sh;
logic [31:0] badv_sh;

// expected read data for one port under this cycle's inputs
function automatic logic [31:0] expected_read(input logic [6:0] addr, input bit port2);
    regfile_pkg::reg_addr_u a;
    a.raw = addr;
    if (a.raw == 7'h00) return 32'h0;
    if (regwrite && a.raw == write_addr) return write_data;
    if (a.f.hilo_sel) begin
        if (a.raw == regfile_pkg::hi_addr) return hl_we ? hl_data[63:32] : hi_sh;
        return hl_we ? hl_data[31:0] : lo_sh;  // every other bit-6 address is lo
    end
    if (a.f.cp0_sel && !port2) return 32'h0;
    if (a.f.cp0_sel) begin
        case (a.f.index)
            regfile_pkg::cp0_status:   return status_sh;
            regfile_pkg::cp0_cause:    return cause_sh;
            regfile_pkg::cp0_epc:      return epc_sh;
            regfile_pkg::cp0_badvaddr: return badv_sh;
            default:                   return 32'h0;
        endcase
    end
    return gpr_sh[a.f.index];
endfunction

function automatic logic expected_int();
    return status_sh[0] && !status_sh[1] && (cause_sh[15:8] & status_sh[15:8]) != 8'h0;
endfunction

// state after the coming edge
task automatic update_model();
    regfile_pkg::reg_addr_u w;
    logic                   cp0_wr;
    w.raw  = write_addr;
    cp0_wr = regwrite && !w.f.hilo_sel && w.f.cp0_sel;
    if (rst) begin
        hi_sh     = '0;
        lo_sh     = '0;
        status_sh = '0;
        cause_sh  = '0;
        epc_sh    = '0;
        badv_sh   = '0;
    end else begin
        if (regwrite && !w.f.hilo_sel && !w.f.cp0_sel && w.f.index != 5'd0) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_we[b]) gpr_sh[w.f.index][8*b +: 8] = write_data[8*b +: 8];
            end
        end
        if (hl_we) begin
            hi_sh = hl_data[63:32];
            lo_sh = hl_data[31:0];
        end else if (regwrite && write_addr == regfile_pkg::hi_addr) begin
            hi_sh = write_data;
        end else if (regwrite && write_addr == regfile_pkg::lo_addr) begin
            lo_sh = write_data;
        end
        if (cp0_wr && w.f.index == regfile_pkg::cp0_status) begin
            status_sh[15:8] = write_data[15:8];  // IM
            status_sh[1:0]  = write_data[1:0];   // EXL, IE
        end
        if (cp0_wr && w.f.index == regfile_pkg::cp0_cause) cause_sh[9:8] = write_data[9:8];
        if (cp0_wr && w.f.index == regfile_pkg::cp0_epc) epc_sh = write_data;
        if (eret) status_sh[1] = 1'b0;
        cause_sh[15:10] = hw_int;
        if (exc_we) begin
            status_sh[1]  = 1'b1;
            cause_sh[6:2] = exc_code;
            cause_sh[31]  = branch_delay;
            epc_sh        = epc;
            badv_sh       = badaddr;
        end
    end
endtask

`endif

/* bench/register_file_tb.sv */
`timescale 1ns/1ps

module register_file_tb;

    localparam int n_gpr_rand = 200;
    localparam int n_bypass   = 40;
    localparam int n_int      = 100;
    // reset, gpr fill and sweep, scripted steps, then the random loops
    localparam int run_cycles = 10 + 31 + 32 + 30 + n_gpr_rand + n_bypass + n_int;

    logic        clk;
    logic        rst          = 1'b1;
    logic        regwrite     = 1'b0;
    logic [6:0]  write_addr   = 7'h00;
    logic [31:0] write_data   = 32'h0;
    logic [3:0]  byte_we      = 4'hf;
    logic [6:0]  read_addr_1  = 7'h00;
    logic [6:0]  read_addr_2  = 7'h00;
    logic        hl_we        = 1'b0;
    logic [63:0] hl_data      = 64'h0;
    logic        exc_we       = 1'b0;
    logic        eret         = 1'b0;
    logic [4:0]  exc_code     = 5'h0;
    logic        branch_delay = 1'b0;
    logic [31:0] epc          = 32'h0;
    logic [31:0] badaddr      = 32'h0;
    logic [5:0]  hw_int       = 6'h0;
    logic [31:0] read_data_1, read_data_2, status_data, cause_data, epc_data;
    logic        int_request;
    int          seed   = 5;
    int          errors = 0;
    int          checks = 0;
    string       test_name = "reset";

    `include "regfile_model.svh"

    register_file UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(run_cycles * 20 + 1000);
        $display("watchdog timeout, stimulus did not complete");
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    // drives one cycle of inputs with random data fields
    // strobes are {hl_we, exc_we, eret}
    task automatic step(input logic wr, input logic [6:0] wa, input logic [3:0] be,
                        input logic [6:0] a1, input logic [6:0] a2, input logic [2:0] strobes);
        @(posedge clk);
        #2;
        regwrite     = wr;
        write_addr   = wa;
        write_data   = rand_word();
        byte_we      = be;
        read_addr_1  = a1;
        read_addr_2  = a2;
        hl_we        = strobes[2];
        hl_data      = {rand_word(), rand_word()};
        exc_we       = strobes[1];
        eret         = strobes[0];
        exc_code     = 5'(rand_word());
        branch_delay = 1'(rand_word());
        epc          = rand_word();
        badaddr      = rand_word();
    endtask

    task automatic compare_value(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // sample just before the edge, then move the model across it
    always begin
        @(posedge clk);
        #18;
        if (!rst) begin
            compare_value("read_data_1", expected_read(read_addr_1, 1'b0), read_data_1);
            compare_value("read_data_2", expected_read(read_addr_2, 1'b1), read_data_2);
            compare_value("status_data", status_sh, status_data);
            compare_value("cause_data", cause_sh, cause_data);
            compare_value("epc_data", epc_sh, epc_data);
            compare_value("int_request", {31'h0, expected_int()}, {31'h0, int_request});
        end
        update_model();
    end

    initial begin
        logic [31:0] r;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        test_name = "reset_values";
        step(1'b0, 7'h00, 4'hf, 7'h7f, 7'h2c, 3'b000);
        step(1'b0, 7'h00, 4'hf, 7'h40, 7'h2d, 3'b000);
        step(1'b1, 7'h00, 4'hf, 7'h00, 7'h00, 3'b000);  // write to r0
        step(1'b0, 7'h00, 4'hf, 7'h00, 7'h00, 3'b000);

        test_name = "gpr_fill";
        for (int i = 1; i < 32; i++) step(1'b1, 7'(i), 4'hf, 7'(i), 7'(i - 1), 3'b000);
        test_name = "gpr_masked";
        repeat (n_gpr_rand) begin
            r = rand_word();
            step(1'b1, {2'b00, r[4:0]}, r[8:5], {2'b00, r[13:9]}, {2'b00, r[18:14]}, 3'b000);
        end
        test_name = "gpr_sweep";
        for (int i = 0; i < 32; i++) step(1'b0, 7'h00, 4'hf, 7'(i), 7'(31 - i), 3'b000);

        test_name = "bypass";
        for (int k = 0; k < n_bypass; k++) begin
            r = rand_word();
            if (k % 2 == 0) begin
                // write_data on one port and the hl_data half on the other
                step(1'b1, (k % 4 == 0) ? regfile_pkg::hi_addr : regfile_pkg::lo_addr, 4'hf,
                     regfile_pkg::hi_addr, regfile_pkg::lo_addr, 3'b100);
            end else begin
                step(1'b1, {2'b00, r[4:0]}, r[8:5], {2'b00, r[4:0]}, {1'b1, r[14:9]}, 3'b100);
            end
        end

        test_name = "hilo";
        step(1'b1, regfile_pkg::hi_addr, 4'hf, 7'h7f, 7'h55, 3'b000);
        step(1'b1, regfile_pkg::lo_addr, 4'h0, 7'h7f, 7'h55, 3'b000);  // lanes ignored
        step(1'b1, 7'h41, 4'hf, 7'h7f, 7'h55, 3'b000);  // unused bit-6 address is dropped
        step(1'b0, 7'h00, 4'hf, 7'h7f, 7'h55, 3'b000);
        step(1'b0, 7'h00, 4'hf, 7'h7f, 7'h40, 3'b100);
        step(1'b1, regfile_pkg::hi_addr, 4'hf, 7'h40, 7'h60, 3'b100);  // pair beats mthi
        step(1'b0, 7'h00, 4'hf, 7'h7f, 7'h40, 3'b000);

        test_name = "cp0";
        step(1'b1, 7'h2c, 4'hf, 7'h2c, 7'h2c, 3'b000);
        step(1'b1, 7'h2d, 4'hf, 7'h2c, 7'h2d, 3'b000);
        step(1'b1, 7'h2e, 4'h1, 7'h2d, 7'h2e, 3'b000);
        step(1'b1, 7'h28, 4'hf, 7'h2e, 7'h28, 3'b000);  // badvaddr is read-only
        step(1'b1, 7'h3f, 4'hf, 7'h3f, 7'h28, 3'b000);
        step(1'b0, 7'h00, 4'hf, 7'h3f, 7'h3f, 3'b000);
        test_name = "exception";
        step(1'b0, 7'h00, 4'hf, 7'h2e, 7'h2e, 3'b010);
        step(1'b0, 7'h00, 4'hf, 7'h2c, 7'h28, 3'b000);
        step(1'b0, 7'h00, 4'hf, 7'h2d, 7'h2c, 3'b001);
        step(1'b0, 7'h00, 4'hf, 7'h2d, 7'h2c, 3'b011);  // exception beats eret
        step(1'b1, 7'h2e, 4'hf, 7'h2e, 7'h2e, 3'b010);
        step(1'b1, 7'h2d, 4'hf, 7'h2d, 7'h2d, 3'b010);
        step(1'b0, 7'h00, 4'hf, 7'h2d, 7'h2e, 3'b001);
        step(1'b0, 7'h00, 4'hf, 7'h2c, 7'h2d, 3'b000);

        test_name = "interrupts";
        for (int k = 0; k < n_int; k++) begin
            r = rand_word();
            step(r[6], r[7] ? 7'h2c : 7'h2d, 4'hf, 7'h2c, 7'h2d, {2'b00, ~r[6] & r[8]});
            hw_int = r[5:0];
        end

        step(1'b0, 7'h00, 4'hf, 7'h00, 7'h00, 3'b000);
        @(posedge clk);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+bench
design/regfile_pkg.sv
design/gpr_bank.sv
design/hilo_regs.sv
design/cp0_regs.sv
design/register_file.sv
bench/register_file_tb.sv

/* Makefile */
SRCS = $(shell grep -v '^+' files.f) bench/regfile_model.svh

.PHONY: run clean

run: obj_dir/Vregister_file_tb
	./obj_dir/Vregister_file_tb | tee sim.log
	grep -q -F '*** TEST PASSED ***' sim.log

obj_dir/Vregister_file_tb: $(SRCS) files.f
	verilator --binary --timing --assert -f files.f --top-module register_file_tb

clean:
	rm -rf obj_dir sim.log
